//--- design/imuldiv_msg_pkg.sv
// message package for the multiply/divide unit
// function codes, request struct and result type

`default_nettype none

package imuldiv_msg_pkg;

  // operand width, fixed for the whole unit
  localparam int OPND_W = 32;

  // ----------------------------------------
  // function codes
  // ----------------------------------------
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } imuldiv_fn_e;

  // request message, 66 bits
  typedef struct packed {
    imuldiv_fn_e       fn;
    logic [OPND_W-1:0] a;
    logic [OPND_W-1:0] b;
  } imuldiv_req_t;

  // ----------------------------------------
  // result message, 64 bits
  // ----------------------------------------
  // mul: full signed product
  // div/divu: remainder in upper half, quotient in lower half
  //
  // divide by zero: quotient all ones, remainder is the dividend
  // most negative / -1 (div only): quotient is the dividend, remainder zero
  // div signs: quotient negative when operand signs differ,
  // remainder follows the sign of the dividend
  typedef logic [2*OPND_W-1:0] imuldiv_result_t;

endpackage

`default_nettype wire

//--- design/imuldiv_ctrl_pkg.sv
// control package for the iterative engines
// state encoding and iteration counter width

`default_nettype none

package imuldiv_ctrl_pkg;

  // ----------------------------------------
  // engine states
  // ----------------------------------------
  // idle: waits for a request
  // calc: one bit per cycle, 32 cycles
  // fix: sign correction and special cases
  // done: holds the response until taken
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_fix  = 2'd2,
    st_done = 2'd3
  } iter_state_e;

  // counts 31 down to 0
  localparam int ITER_CNT_W = 5;

endpackage

`default_nettype wire

//--- design/imuldiv_req_if.sv
// request channel from the top level to one engine
// val/rdy handshake with function code and operands

`timescale 1ns/1ps
`default_nettype none

interface imuldiv_req_if import imuldiv_msg_pkg::*; ();

  // handshake
  logic val;
  logic rdy;

  // payload, held stable by the sender until taken
  imuldiv_fn_e       fn;
  logic [OPND_W-1:0] a;
  logic [OPND_W-1:0] b;

  // ----------------------------------------
  // top level side
  // ----------------------------------------
  modport issue (
    output val,
    output fn,
    output a,
    output b,
    input  rdy
  );

  // ----------------------------------------
  // engine side, rdy from engine state only
  // ----------------------------------------
  modport engine (
    input  val,
    input  fn,
    input  a,
    input  b,
    output rdy
  );

endinterface

`default_nettype wire

//--- design/imuldiv_msg_buffer.sv
// single entry val/rdy buffer
// payload type set by the instantiating module

`timescale 1ns/1ps
`default_nettype none

module imuldiv_msg_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_val,
  output logic     in_rdy,
  input  payload_t in_data,
  output logic     out_val,
  input  logic     out_rdy,
  output payload_t out_data
);

  logic     full_q;
  payload_t data_q;

  // accept when empty, or when the held entry leaves this cycle
  assign in_rdy   = !full_q || out_rdy;
  assign out_val  = full_q;
  assign out_data = data_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (in_val && in_rdy) begin
      full_q <= 1'b1;
    end else if (out_val && out_rdy) begin
      full_q <= 1'b0;
    end
  end

  // new entry replaces a drained one in the same cycle
  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin
      data_q <= in_data;
    end
  end

  // a stalled entry must not change under the receiver
  assert property (@(posedge clk) disable iff (reset)
    (out_val && !out_rdy) |=> (out_val && $stable(out_data)));

endmodule

`default_nettype wire

//--- design/imuldiv_mul_iterative.sv
// iterative shift-add multiplier, signed
// wrapper, datapath and control

`timescale 1ns/1ps
`default_nettype none

module imuldiv_mul_iterative import imuldiv_msg_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  imuldiv_req_if.engine   req,
  output logic            resp_val,
  input  logic            resp_rdy,
  output imuldiv_result_t resp_result
);

  logic load_en;
  logic calc_en;
  logic add_en;
  logic fix_en;
  logic counter_is_zero;
  logic b_lsb;

  // registers and arithmetic
  imuldiv_mul_dpath i_dpath (
    .clk             (clk),
    .req             (req),
    .load_en         (load_en),
    .calc_en         (calc_en),
    .add_en          (add_en),
    .fix_en          (fix_en),
    .counter_is_zero (counter_is_zero),
    .b_lsb           (b_lsb),
    .result          (resp_result)
  );

  // sequencing and handshake
  imuldiv_mul_ctrl i_ctrl (
    .clk             (clk),
    .reset           (reset),
    .req             (req),
    .resp_val        (resp_val),
    .resp_rdy        (resp_rdy),
    .counter_is_zero (counter_is_zero),
    .b_lsb           (b_lsb),
    .load_en         (load_en),
    .calc_en         (calc_en),
    .add_en          (add_en),
    .fix_en          (fix_en)
  );

endmodule

// ----------------------------------------
// datapath
// ----------------------------------------
module imuldiv_mul_dpath import imuldiv_msg_pkg::*; import imuldiv_ctrl_pkg::*; (
  input  logic            clk,
  imuldiv_req_if.engine   req,
  input  logic            load_en,
  input  logic            calc_en,
  input  logic            add_en,
  input  logic            fix_en,
  output logic            counter_is_zero,
  output logic            b_lsb,
  output imuldiv_result_t result
);

  logic [2*OPND_W-1:0]   a_q;
  logic [OPND_W-1:0]     b_q;
  logic [2*OPND_W-1:0]   acc_q;
  logic                  sign_a_q;
  logic                  sign_b_q;
  logic [ITER_CNT_W-1:0] cnt_q;
  logic [OPND_W-1:0]     a_mag;
  logic [OPND_W-1:0]     b_mag;

  // magnitudes, most negative maps to 2^31 as unsigned
  assign a_mag = req.a[OPND_W-1] ? -req.a : req.a;
  assign b_mag = req.b[OPND_W-1] ? -req.b : req.b;

  assign counter_is_zero = (cnt_q == '0);
  assign b_lsb           = b_q[0];
  assign result          = acc_q;

  always_ff @(posedge clk) begin
    if (load_en) begin
      a_q      <= {{OPND_W{1'b0}}, a_mag};
      b_q      <= b_mag;
      acc_q    <= '0;
      sign_a_q <= req.a[OPND_W-1];
      sign_b_q <= req.b[OPND_W-1];
      cnt_q    <= '1;
    end else if (calc_en) begin
      // add the shifted multiplicand for each set bit of b
      if (add_en) begin
        acc_q <= acc_q + a_q;
      end
      a_q   <= a_q << 1;
      b_q   <= b_q >> 1;
      cnt_q <= cnt_q - 1'b1;
    end else if (fix_en && (sign_a_q ^ sign_b_q)) begin
      acc_q <= -acc_q;
    end
  end

endmodule

// ----------------------------------------
// control
// ----------------------------------------
module imuldiv_mul_ctrl import imuldiv_ctrl_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  imuldiv_req_if.engine req,
  output logic          resp_val,
  input  logic          resp_rdy,
  input  logic          counter_is_zero,
  input  logic          b_lsb,
  output logic          load_en,
  output logic          calc_en,
  output logic          add_en,
  output logic          fix_en
);

  iter_state_e state_q;
  iter_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: if (req.val) state_d = st_calc;
      // last step runs with the counter at zero
      st_calc: if (counter_is_zero) state_d = st_fix;
      st_fix:  state_d = st_done;
      st_done: if (resp_rdy) state_d = st_idle;
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  assign req.rdy  = (state_q == st_idle);
  assign load_en  = req.val && req.rdy;
  assign calc_en  = (state_q == st_calc);
  assign add_en   = calc_en && b_lsb;
  assign fix_en   = (state_q == st_fix);
  assign resp_val = (state_q == st_done);

  // datapath counter loaded for a full 32 steps
  assert property (@(posedge clk) disable iff (reset)
    load_en |=> !counter_is_zero);

  // response held until the consumer takes it
  assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> resp_val);

endmodule

`default_nettype wire

//--- design/imuldiv_div_iterative.sv
// iterative restoring divider, div and divu
// wrapper, datapath and control

`timescale 1ns/1ps
`default_nettype none

module imuldiv_div_iterative import imuldiv_msg_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  imuldiv_req_if.engine   req,
  output logic            resp_val,
  input  logic            resp_rdy,
  output imuldiv_result_t resp_result
);

  logic load_en;
  logic calc_en;
  logic fix_en;
  logic is_signed;
  logic counter_is_zero;

  imuldiv_div_dpath i_dpath (
    .clk             (clk),
    .req             (req),
    .load_en         (load_en),
    .calc_en         (calc_en),
    .fix_en          (fix_en),
    .is_signed       (is_signed),
    .counter_is_zero (counter_is_zero),
    .result          (resp_result)
  );

  imuldiv_div_ctrl i_ctrl (
    .clk             (clk),
    .reset           (reset),
    .req             (req),
    .resp_val        (resp_val),
    .resp_rdy        (resp_rdy),
    .counter_is_zero (counter_is_zero),
    .load_en         (load_en),
    .calc_en         (calc_en),
    .fix_en          (fix_en),
    .is_signed       (is_signed)
  );

endmodule

// ----------------------------------------
// datapath
// ----------------------------------------
module imuldiv_div_dpath import imuldiv_msg_pkg::*; import imuldiv_ctrl_pkg::*; (
  input  logic            clk,
  imuldiv_req_if.engine   req,
  input  logic            load_en,
  input  logic            calc_en,
  input  logic            fix_en,
  input  logic            is_signed,
  output logic            counter_is_zero,
  output imuldiv_result_t result
);

  localparam logic [OPND_W-1:0] MOST_NEG = {1'b1, {(OPND_W-1){1'b0}}};

  // remainder in the upper half, quotient shifts in at the bottom
  logic [2*OPND_W-1:0]   rq_q;
  logic [OPND_W-1:0]     dvsr_q;
  logic                  q_neg_q;
  logic                  r_neg_q;
  logic                  zero_q;
  logic                  ovf_q;
  logic [ITER_CNT_W-1:0] cnt_q;
  logic [OPND_W-1:0]     a_mag;
  logic [OPND_W-1:0]     b_mag;
  logic [OPND_W:0]       trial;
  logic [OPND_W-1:0]     q_fix;
  logic [OPND_W-1:0]     r_fix;

  assign a_mag = (is_signed && req.a[OPND_W-1]) ? -req.a : req.a;
  assign b_mag = (is_signed && req.b[OPND_W-1]) ? -req.b : req.b;

  // shifted partial remainder is 33 bits, borrow in the top bit
  assign trial = rq_q[2*OPND_W-1:OPND_W-1] - {1'b0, dvsr_q};

  // special cases first, then the sign rules
  // sign and overflow flags only count for div
  always_comb begin
    if (zero_q) begin
      q_fix = '1;
    end else if (is_signed && ovf_q) begin
      q_fix = MOST_NEG;
    end else begin
      q_fix = (is_signed && q_neg_q) ? -rq_q[OPND_W-1:0] : rq_q[OPND_W-1:0];
    end
    if (is_signed && ovf_q) begin
      r_fix = '0;
    end else begin
      // divide by zero leaves the dividend magnitude here
      r_fix = (is_signed && r_neg_q) ? -rq_q[2*OPND_W-1:OPND_W]
                                     : rq_q[2*OPND_W-1:OPND_W];
    end
  end

  assign counter_is_zero = (cnt_q == '0);
  assign result          = rq_q;

  always_ff @(posedge clk) begin
    if (load_en) begin
      rq_q    <= {{OPND_W{1'b0}}, a_mag};
      dvsr_q  <= b_mag;
      // raw operand signs, qualified by the recorded fn in fix
      q_neg_q <= req.a[OPND_W-1] ^ req.b[OPND_W-1];
      r_neg_q <= req.a[OPND_W-1];
      zero_q  <= (req.b == '0);
      ovf_q   <= (req.a == MOST_NEG) && (req.b == '1);
      cnt_q   <= '1;
    end else if (calc_en) begin
      if (!trial[OPND_W]) begin
        // subtraction fits, quotient bit is one
        rq_q <= {trial[OPND_W-1:0], rq_q[OPND_W-2:0], 1'b1};
      end else begin
        // restore, quotient bit is zero
        rq_q <= {rq_q[2*OPND_W-2:0], 1'b0};
      end
      cnt_q <= cnt_q - 1'b1;
    end else if (fix_en) begin
      rq_q <= {r_fix, q_fix};
    end
  end

endmodule

// ----------------------------------------
// control
// ----------------------------------------
module imuldiv_div_ctrl import imuldiv_msg_pkg::*; import imuldiv_ctrl_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  imuldiv_req_if.engine req,
  output logic          resp_val,
  input  logic          resp_rdy,
  input  logic          counter_is_zero,
  output logic          load_en,
  output logic          calc_en,
  output logic          fix_en,
  output logic          is_signed
);

  iter_state_e state_q;
  iter_state_e state_d;
  logic        signed_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: if (req.val) state_d = st_calc;
      st_calc: if (counter_is_zero) state_d = st_fix;
      st_fix:  state_d = st_done;
      st_done: if (resp_rdy) state_d = st_idle;
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q  <= st_idle;
      signed_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (load_en) begin
        signed_q <= (req.fn == fn_div);
      end
    end
  end

  assign req.rdy  = (state_q == st_idle);
  assign load_en  = req.val && req.rdy;
  assign calc_en  = (state_q == st_calc);
  assign fix_en   = (state_q == st_fix);
  assign resp_val = (state_q == st_done);

  // live fn while loading, recorded copy for the fix step
  assign is_signed = (state_q == st_idle) ? (req.fn == fn_div) : signed_q;

  // no new request taken until the current response has left
  assert property (@(posedge clk) disable iff (reset)
    load_en |=> (!req.rdy until (resp_val && resp_rdy)));

endmodule

`default_nettype wire

//--- design/imuldiv_unit.sv
// multiply/divide unit top level
// input buffer, in-order dispatch, response select, output buffer

`timescale 1ns/1ps
`default_nettype none

module imuldiv_unit import imuldiv_msg_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              req_val,
  output logic              req_rdy,
  input  imuldiv_fn_e       req_fn,
  input  logic [OPND_W-1:0] req_a,
  input  logic [OPND_W-1:0] req_b,
  output logic              resp_val,
  input  logic              resp_rdy,
  output imuldiv_result_t   resp_result
);

  imuldiv_req_t    req_msg;
  logic            ib_val;
  logic            ib_rdy;
  imuldiv_req_t    ib_msg;
  logic            to_div;
  logic            outstanding_q;
  logic            owner_div_q;
  logic            mul_resp_val;
  logic            mul_resp_rdy;
  imuldiv_result_t mul_result;
  logic            div_resp_val;
  logic            div_resp_rdy;
  imuldiv_result_t div_result;
  logic            ob_val;
  logic            ob_rdy;
  imuldiv_result_t ob_msg;

  imuldiv_req_if mul_req ();
  imuldiv_req_if div_req ();

  assign req_msg = '{fn: req_fn, a: req_a, b: req_b};

  imuldiv_msg_buffer #(.payload_t(imuldiv_req_t)) i_in_buf (
    .clk      (clk),
    .reset    (reset),
    .in_val   (req_val),
    .in_rdy   (req_rdy),
    .in_data  (req_msg),
    .out_val  (ib_val),
    .out_rdy  (ib_rdy),
    .out_data (ib_msg)
  );

  // ----------------------------------------
  // dispatch, one request in an engine at a time
  // ----------------------------------------
  assign to_div = (ib_msg.fn != fn_mul);
  assign ib_rdy = !outstanding_q && (to_div ? div_req.rdy : mul_req.rdy);

  assign mul_req.val = ib_val && !outstanding_q && !to_div;
  assign mul_req.fn  = ib_msg.fn;
  assign mul_req.a   = ib_msg.a;
  assign mul_req.b   = ib_msg.b;
  assign div_req.val = ib_val && !outstanding_q && to_div;
  assign div_req.fn  = ib_msg.fn;
  assign div_req.a   = ib_msg.a;
  assign div_req.b   = ib_msg.b;

  // busy from issue until the response enters the output buffer
  always_ff @(posedge clk) begin
    if (reset) begin
      outstanding_q <= 1'b0;
      owner_div_q   <= 1'b0;
    end else if (ib_val && ib_rdy) begin
      outstanding_q <= 1'b1;
      owner_div_q   <= to_div;
    end else if (ob_val && ob_rdy) begin
      outstanding_q <= 1'b0;
    end
  end

  imuldiv_mul_iterative i_mul (
    .clk         (clk),
    .reset       (reset),
    .req         (mul_req),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy),
    .resp_result (mul_result)
  );

  imuldiv_div_iterative i_div (
    .clk         (clk),
    .reset       (reset),
    .req         (div_req),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy),
    .resp_result (div_result)
  );

  // response from the engine that owns the outstanding request
  assign ob_val       = owner_div_q ? div_resp_val : mul_resp_val;
  assign ob_msg       = owner_div_q ? div_result : mul_result;
  assign mul_resp_rdy = ob_rdy && !owner_div_q;
  assign div_resp_rdy = ob_rdy && owner_div_q;

  imuldiv_msg_buffer #(.payload_t(imuldiv_result_t)) i_out_buf (
    .clk      (clk),
    .reset    (reset),
    .in_val   (ob_val),
    .in_rdy   (ob_rdy),
    .in_data  (ob_msg),
    .out_val  (resp_val),
    .out_rdy  (resp_rdy),
    .out_data (resp_result)
  );

endmodule

`default_nettype wire

//--- bench/imuldiv_tb.sv
// testbench for the multiply/divide unit
// random and directed requests, reference model, ordered response checks

`timescale 1ns/1ps
`default_nettype none

module imuldiv_tb import imuldiv_msg_pkg::*; ();

  // operation counts per phase
  localparam int n_mul     = 200;
  localparam int n_div     = 200;
  localparam int n_special = 8;
  localparam int n_mixed   = 80;
  localparam int n_stall   = 4;
  localparam int n_ops     = n_mul + n_div + n_special + n_mixed + n_stall;
  // generous bound, two full engine passes per operation
  localparam int timeout_limit = 2 * n_ops * 40 + 100;

  localparam logic [OPND_W-1:0] most_neg = {1'b1, {(OPND_W-1){1'b0}}};

  logic              clk;
  logic              reset;
  logic              req_val;
  logic              req_rdy;
  imuldiv_fn_e       req_fn;
  logic [OPND_W-1:0] req_a;
  logic [OPND_W-1:0] req_b;
  logic              resp_val;
  logic              resp_rdy;
  imuldiv_result_t   resp_result;

  integer seed = 23;
  // 0 always ready, 1 random about 30% low, 2 held low
  int rdy_mode = 0;
  int n_sent = 0;
  int n_recv = 0;
  int cycle_cnt = 0;
  imuldiv_result_t exp_q[$];

  imuldiv_unit i_dut (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  always #5 clk = !clk;

  // ----------------------------------------
  // error handling and compares
  // ----------------------------------------
  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // remainder or product high half is checked apart from the low half
  task automatic check_result(input imuldiv_result_t exp, input imuldiv_result_t act,
                              input string name);
    if (exp[2*OPND_W-1:OPND_W] !== act[2*OPND_W-1:OPND_W]) begin
      stop_on_error($sformatf("** Error at %0t: %s[63:32] expected %h actual %h",
        $time, name, exp[2*OPND_W-1:OPND_W], act[2*OPND_W-1:OPND_W]));
    end
    if (exp[OPND_W-1:0] !== act[OPND_W-1:0]) begin
      stop_on_error($sformatf("** Error at %0t: %s[31:0] expected %h actual %h",
        $time, name, exp[OPND_W-1:0], act[OPND_W-1:0]));
    end
  endtask

  task automatic check_flag(input bit exp, input logic act, input string name);
    if (act !== exp) begin
      stop_on_error($sformatf("** Error at %0t: %s expected %0b actual %0b",
        $time, name, exp, act));
    end
  endtask

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic imuldiv_result_t model_mul(input logic [OPND_W-1:0] a,
                                                input logic [OPND_W-1:0] b);
    longint sa;
    longint sb;
    sa = $signed(a);
    sb = $signed(b);
    return sa * sb;
  endfunction

  // remainder in the upper half, quotient in the lower half
  function automatic imuldiv_result_t model_div(input imuldiv_fn_e fn,
                                                input logic [OPND_W-1:0] a,
                                                input logic [OPND_W-1:0] b);
    logic [OPND_W-1:0] q;
    logic [OPND_W-1:0] r;
    logic [OPND_W-1:0] ma;
    logic [OPND_W-1:0] mb;
    logic              neg_a;
    logic              neg_b;
    neg_a = (fn == fn_div) && a[OPND_W-1];
    neg_b = (fn == fn_div) && b[OPND_W-1];
    if (b == '0) begin
      // divide by zero
      q = '1;
      r = a;
    end else if ((fn == fn_div) && (a == most_neg) && (b == '1)) begin
      // signed overflow
      q = a;
      r = '0;
    end else begin
      ma = neg_a ? -a : a;
      mb = neg_b ? -b : b;
      q  = ma / mb;
      r  = ma % mb;
      // quotient sign from both operands, remainder follows the dividend
      if (neg_a != neg_b) begin
        q = -q;
      end
      if (neg_a) begin
        r = -r;
      end
    end
    return {r, q};
  endfunction

  function automatic imuldiv_result_t expect_result(input imuldiv_fn_e fn,
                                                    input logic [OPND_W-1:0] a,
                                                    input logic [OPND_W-1:0] b);
    if (fn == fn_mul) begin
      return model_mul(a, b);
    end else begin
      return model_div(fn, a, b);
    end
  endfunction

  // full range value, with corner values mixed in about a quarter of the time
  function automatic logic [OPND_W-1:0] rand_opnd();
    int pick;
    pick = {$random(seed)} % 16;
    case (pick)
      0: return '0;
      1: return 1;
      2: return '1;
      3: return most_neg;
      default: return $random(seed);
    endcase
  endfunction

  // ----------------------------------------
  // stimulus tasks, entered 1 ns after an edge
  // ----------------------------------------
  task automatic send_req(input imuldiv_fn_e fn, input logic [OPND_W-1:0] a,
                          input logic [OPND_W-1:0] b);
    req_val = 1'b1;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    @(posedge clk);
    while (!req_rdy) begin
      @(posedge clk);
    end
    // transfer took place at this edge
    exp_q.push_back(expect_result(fn, a, b));
    n_sent++;
    #1;
    req_val = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // count read after the edge, once the monitor has updated it
  task automatic wait_drain();
    while (n_recv != n_sent) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_rdy_low(input int limit);
    int cnt;
    cnt = 0;
    while (req_rdy && (cnt < limit)) begin
      @(posedge clk);
      cnt++;
    end
    if (req_rdy) begin
      stop_on_error("req_rdy never fell while resp_rdy was held low");
    end
    #1;
  endtask

  // ----------------------------------------
  // response side
  // ----------------------------------------
  // mode sampled at the edge, applied 1 ns later
  always @(posedge clk) begin
    int mode_now;
    int coin;
    mode_now = rdy_mode;
    coin     = {$random(seed)} % 10;
    #1;
    case (mode_now)
      1:       resp_rdy = (coin >= 3);
      2:       resp_rdy = 1'b0;
      default: resp_rdy = 1'b1;
    endcase
  end

  // in order compare, plus hold check on a stalled response
  always @(posedge clk) begin
    bit              held;
    imuldiv_result_t held_result;
    imuldiv_result_t exp;
    if (reset) begin
      held = 1'b0;
    end else begin
      if (held) begin
        check_flag(1'b1, resp_val, "resp_val");
        check_result(held_result, resp_result, "resp_result");
      end
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          stop_on_error("a response arrived with no request outstanding");
        end
        exp = exp_q.pop_front();
        check_result(exp, resp_result, "resp_result");
        n_recv++;
      end
      held        = resp_val && !resp_rdy;
      held_result = resp_result;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > timeout_limit) begin
      stop_on_error($sformatf("timeout after %0d cycles, %0d of %0d responses seen",
        cycle_cnt, n_recv, n_sent));
    end
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    imuldiv_fn_e fn;
    clk      = 1'b0;
    reset    = 1'b1;
    req_val  = 1'b0;
    req_fn   = fn_mul;
    req_a    = '0;
    req_b    = '0;
    resp_rdy = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    // idle state right after reset
    @(posedge clk);
    check_flag(1'b0, resp_val, "resp_val");
    check_flag(1'b1, req_rdy, "req_rdy");
    #1;

    // signed products
    for (int i = 0; i < n_mul; i++) begin
      send_req(fn_mul, rand_opnd(), rand_opnd());
    end
    wait_drain();

    // signed and unsigned divides
    for (int i = 0; i < n_div; i++) begin
      fn = ($random(seed) & 1) ? fn_div : fn_divu;
      send_req(fn, rand_opnd(), rand_opnd());
    end
    wait_drain();

    // divide by zero and overflow corners
    send_req(fn_div, 32'd1234, '0);
    send_req(fn_div, 32'hffff_fc00, '0);
    send_req(fn_div, most_neg, '0);
    send_req(fn_divu, 32'hdead_beef, '0);
    send_req(fn_divu, '0, '0);
    send_req(fn_div, most_neg, '1);
    send_req(fn_divu, most_neg, '1);
    send_req(fn_div, 32'hffff_fff9, 32'd2);
    wait_drain();

    // back-pressure and gaps, all functions mixed
    rdy_mode = 1;
    for (int i = 0; i < n_mixed; i++) begin
      case ({$random(seed)} % 3)
        0:       fn = fn_mul;
        1:       fn = fn_div;
        default: fn = fn_divu;
      endcase
      send_req(fn, rand_opnd(), rand_opnd());
      idle_cycles({$random(seed)} % 4);
    end
    rdy_mode = 0;
    wait_drain();

    // consumer stalls until the unit stops taking requests
    rdy_mode = 2;
    idle_cycles(2);
    for (int i = 0; i < n_stall - 1; i++) begin
      send_req(fn_mul, rand_opnd(), rand_opnd());
    end
    wait_rdy_low(200);
    // first response waits in the output buffer, input side stays closed
    repeat (20) begin
      @(posedge clk);
      check_flag(1'b0, req_rdy, "req_rdy");
      check_flag(1'b1, resp_val, "resp_val");
    end
    #1;
    rdy_mode = 0;
    send_req(fn_divu, rand_opnd(), rand_opnd());
    wait_drain();

    // nothing repeated after the last response
    repeat (5) begin
      @(posedge clk);
      check_flag(1'b0, resp_val, "resp_val");
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
design/imuldiv_msg_pkg.sv
design/imuldiv_ctrl_pkg.sv
design/imuldiv_req_if.sv
design/imuldiv_msg_buffer.sv
design/imuldiv_mul_iterative.sv
design/imuldiv_div_iterative.sv
design/imuldiv_unit.sv
bench/imuldiv_tb.sv

//--- Bender.yml
package:
  name: imuldiv

sources:
  # packages first, then interface, leaf modules and top level
  - design/imuldiv_msg_pkg.sv
  - design/imuldiv_ctrl_pkg.sv
  - design/imuldiv_req_if.sv
  - design/imuldiv_msg_buffer.sv
  - design/imuldiv_mul_iterative.sv
  - design/imuldiv_div_iterative.sv
  - design/imuldiv_unit.sv
  - target: test
    files:
      - bench/imuldiv_tb.sv
